//--- rtl/memStage_params.svh
// memory stage parameters for widths, interrupt lines and exception vector
`ifndef MEM_STAGE_PARAMS_SVH
`define MEM_STAGE_PARAMS_SVH

// data and address width
`define XLEN 32

// hardware interrupt lines, mapped to Status IM[7:2]
`define INT_NUM 6

// boot exception vector base
`define EXC_VEC_BASE 32'hBFC00200

// general exception entry offset
`define EXC_VEC_OFFSET 32'h00000180

`endif

//--- rtl/pipeTypesPkg.sv
// pipeline control types for loads and stores carried down to memory
package pipeTypesPkg;

    // access size encodings, shared by loads and stores
    localparam logic [1:0] sizeByte = 2'd0;
    localparam logic [1:0] sizeHalf = 2'd1;
    localparam logic [1:0] sizeWord = 2'd2;

    typedef struct packed {
        logic       readMem;  // instruction loads
        logic [1:0] size;
    } loadType;

    typedef struct packed {
        logic       dmWr;     // instruction stores
        logic [1:0] size;
    } storeType;

endpackage

//--- rtl/excPkg.sv
// exception codes and exception flags carried by the pipeline
package excPkg;

    // Cause.ExcCode values, None marks no exception
    typedef enum logic [4:0] {
        Int  = 5'd0,
        AdEL = 5'd4,
        AdES = 5'd5,
        Sys  = 5'd8,
        Bp   = 5'd9,
        RI   = 5'd10,
        Ov   = 5'd12,
        None = 5'd31
    } excCode;

    // set by fetch, decode and execute
    typedef struct packed {
        logic fetchAdEL;
        logic reservedInstr;
        logic syscall;
        logic breakPt;
        logic overflow;
    } excFlags;

    // alignment faults found in memory
    typedef struct packed {
        logic loadMisaligned;
        logic storeMisaligned;
    } addrFault;

endpackage

//--- rtl/memReg.sv
// memory stage pipeline register, holds on stall and clears to a bubble on flush
`include "memStage_params.svh"

module memReg (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   memFlush,
    input  logic                   memWr,

    input  logic [`XLEN-1:0]       exeAluOut,
    input  logic [`XLEN-1:0]       exeStoreData,
    input  logic [`XLEN-1:0]       exePc,
    input  pipeTypesPkg::loadType  exeLoadType,
    input  pipeTypesPkg::storeType exeStoreType,
    input  excPkg::excFlags        exeExc,
    input  logic                   exeIsEret,
    input  logic                   exeInDelaySlot,

    output logic [`XLEN-1:0]       memAluOut,
    output logic [`XLEN-1:0]       memStoreData,
    output logic [`XLEN-1:0]       memPc,
    output pipeTypesPkg::loadType  memLoadType,
    output pipeTypesPkg::storeType memStoreType,
    output excPkg::excFlags        memExc,
    output logic                   memIsEret,
    output logic                   memInDelaySlot
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memAluOut      <= '0;
            memStoreData   <= '0;
            memPc          <= '0;
            memLoadType    <= '0;
            memStoreType   <= '0;
            memExc         <= '0;
            memIsEret      <= 1'b0;
            memInDelaySlot <= 1'b0;
        end else if (memFlush) begin  // flush beats write
            memAluOut      <= '0;
            memStoreData   <= '0;
            memPc          <= '0;
            memLoadType    <= '0;
            memStoreType   <= '0;
            memExc         <= '0;
            memIsEret      <= 1'b0;
            memInDelaySlot <= 1'b0;
        end else if (memWr) begin
            memAluOut      <= exeAluOut;
            memStoreData   <= exeStoreData;
            memPc          <= exePc;
            memLoadType    <= exeLoadType;
            memStoreType   <= exeStoreType;
            memExc         <= exeExc;
            memIsEret      <= exeIsEret;
            memInDelaySlot <= exeInDelaySlot;
        end
    end

    // hazard unit must always drive the stage controls
    ctrlKnown: assert property (@(posedge clk) disable iff (!arstN)
        !$isunknown({memWr, memFlush}));

endmodule

//--- rtl/exceptionUnit.sv
// exception unit, prioritises carried exceptions and detects pending interrupts
`include "memStage_params.svh"

module exceptionUnit (
    input  excPkg::excFlags            memExc,
    input  logic [`INT_NUM-1:0]        interrupt,
    input  logic [`INT_NUM+1:2]        statusIm,  // IM7..IM2
    input  logic                       statusIe,
    output excPkg::excCode             pipeExc,
    output logic                       intPending
);

    // earliest stage first
    always_comb begin
        if (memExc.fetchAdEL) begin
            pipeExc = excPkg::AdEL;
        end else if (memExc.reservedInstr) begin
            pipeExc = excPkg::RI;
        end else if (memExc.syscall) begin
            pipeExc = excPkg::Sys;
        end else if (memExc.breakPt) begin
            pipeExc = excPkg::Bp;
        end else if (memExc.overflow) begin
            pipeExc = excPkg::Ov;
        end else begin
            pipeExc = excPkg::None;
        end
    end

    // line i lands on IP[i+2]
    assign intPending = statusIe && |(interrupt & statusIm);

endmodule

//--- rtl/storeAligner.sv
// store aligner, builds byte strobes and lane data and checks access alignment
`include "memStage_params.svh"

module storeAligner (
    input  logic [`XLEN-1:0]       memAluOut,
    input  logic [`XLEN-1:0]       memStoreData,
    input  pipeTypesPkg::loadType  memLoadType,
    input  pipeTypesPkg::storeType memStoreType,
    output logic [3:0]             wstrb,
    output logic [`XLEN-1:0]       wdata,
    output excPkg::addrFault       fault
);

    logic [1:0] offset;

    assign offset = memAluOut[1:0];

    function automatic logic misaligned(input logic [1:0] size, input logic [1:0] addrLow);
        logic bad;
        bad = 1'b0;
        if (size == pipeTypesPkg::sizeHalf) begin
            bad = addrLow[0];
        end else if (size == pipeTypesPkg::sizeWord) begin
            bad = |addrLow;
        end
        return bad;
    endfunction

    always_comb begin
        wstrb = 4'b0000;
        wdata = memStoreData;
        case (memStoreType.size)
            pipeTypesPkg::sizeByte: begin
                wstrb = 4'b0001 << offset;
                wdata = {4{memStoreData[7:0]}};
            end
            pipeTypesPkg::sizeHalf: begin
                wstrb = offset[1] ? 4'b1100 : 4'b0011;
                wdata = {2{memStoreData[15:0]}};
            end
            default: wstrb = 4'b1111;  // word
        endcase
        if (!memStoreType.dmWr) begin
            wstrb = 4'b0000;  // no lanes without a store
        end
    end

    assign fault.loadMisaligned  = memLoadType.readMem && misaligned(memLoadType.size, offset);
    assign fault.storeMisaligned = memStoreType.dmWr && misaligned(memStoreType.size, offset);

    // decode never marks one instruction as both load and store
    always_comb begin
        oneAccess: assert final ($isunknown({memLoadType.readMem, memStoreType.dmWr})
            || !(memLoadType.readMem && memStoreType.dmWr));
    end

endmodule

//--- rtl/memCommit.sv
// commit block, picks the final exception, keeps EPC/BadVAddr/EXL, gates the data bus
`include "memStage_params.svh"

module memCommit (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   memWr,
    input  logic                   memFlush,
    input  logic                   dreqValid,
    input  excPkg::excCode         pipeExc,
    input  logic                   intPending,
    input  excPkg::addrFault       fault,
    input  logic [`XLEN-1:0]       memPc,
    input  logic [`XLEN-1:0]       memAluOut,
    input  logic                   memInDelaySlot,
    input  logic                   memIsEret,
    input  pipeTypesPkg::loadType  memLoadType,
    input  pipeTypesPkg::storeType memStoreType,

    output logic                   flushException,
    output excPkg::excCode         excCodeOut,
    output logic [`XLEN-1:0]       excVector,
    output logic [`XLEN-1:0]       cp0Epc,
    output logic                   cp0Bd,
    output logic [`XLEN-1:0]       cp0BadVaddr,
    output logic                   cp0Exl,
    output logic                   dbusValid,
    output logic                   dbusWrite,
    output logic [`XLEN-1:0]       dbusAddr
);

    logic excTaken;
    logic eretTaken;

    always_comb begin
        if (intPending && !cp0Exl) begin  // no nesting while EXL set
            excCodeOut = excPkg::Int;
        end else if (pipeExc != excPkg::None) begin
            excCodeOut = pipeExc;
        end else if (fault.loadMisaligned) begin
            excCodeOut = excPkg::AdEL;
        end else if (fault.storeMisaligned) begin
            excCodeOut = excPkg::AdES;
        end else begin
            excCodeOut = excPkg::None;
        end
    end

    assign excTaken       = (excCodeOut != excPkg::None);
    assign eretTaken      = memIsEret && !excTaken;
    assign flushException = excTaken || eretTaken;
    assign excVector      = eretTaken ? cp0Epc : `EXC_VEC_BASE + `EXC_VEC_OFFSET;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cp0Epc      <= '0;
            cp0Bd       <= 1'b0;
            cp0BadVaddr <= '0;
            cp0Exl      <= 1'b0;
        end else if (memWr) begin
            if (excTaken) begin
                cp0Epc <= memInDelaySlot ? memPc - `XLEN'd4 : memPc;  // back to the branch
                cp0Bd  <= memInDelaySlot;
                cp0Exl <= 1'b1;
                if (excCodeOut == excPkg::AdEL && pipeExc == excPkg::AdEL) begin
                    cp0BadVaddr <= memPc;  // fetch fault
                end else if (excCodeOut == excPkg::AdEL || excCodeOut == excPkg::AdES) begin
                    cp0BadVaddr <= memAluOut;
                end
            end else if (eretTaken) begin
                cp0Exl <= 1'b0;
            end
        end
    end

    assign dbusValid = dreqValid && (memLoadType.readMem || memStoreType.dmWr)
                       && !flushException && !memFlush;
    assign dbusWrite = memStoreType.dmWr;
    assign dbusAddr  = memAluOut;

    // a cancelled instruction must not reach the cache
    noBusOnFlush: assert property (@(posedge clk) disable iff (!arstN)
        !(dbusValid && flushException));

endmodule

//--- rtl/memStage.sv
// memory stage top, register plus exception, store alignment and commit blocks
`include "memStage_params.svh"

module memStage (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   memFlush,
    input  logic                   memWr,
    input  logic                   dreqValid,

    input  logic [`XLEN-1:0]       exeAluOut,
    input  logic [`XLEN-1:0]       exeStoreData,
    input  logic [`XLEN-1:0]       exePc,
    input  pipeTypesPkg::loadType  exeLoadType,
    input  pipeTypesPkg::storeType exeStoreType,
    input  excPkg::excFlags        exeExc,
    input  logic                   exeIsEret,
    input  logic                   exeInDelaySlot,

    input  logic [`INT_NUM-1:0]    interrupt,
    input  logic [`INT_NUM+1:2]    statusIm,
    input  logic                   statusIe,

    output logic [`XLEN-1:0]       memPc,
    output logic                   flushException,
    output excPkg::excCode         excCodeOut,
    output logic [`XLEN-1:0]       excVector,
    output logic [`XLEN-1:0]       cp0Epc,
    output logic                   cp0Bd,
    output logic [`XLEN-1:0]       cp0BadVaddr,
    output logic                   cp0Exl,
    output logic                   dbusValid,
    output logic                   dbusWrite,
    output logic [`XLEN-1:0]       dbusAddr,
    output logic [3:0]             wstrb,
    output logic [`XLEN-1:0]       wdata
);

    logic [`XLEN-1:0]       memAluOut;
    logic [`XLEN-1:0]       memStoreData;
    pipeTypesPkg::loadType  memLoadType;
    pipeTypesPkg::storeType memStoreType;
    excPkg::excFlags        memExc;
    logic                   memIsEret;
    logic                   memInDelaySlot;
    excPkg::excCode         pipeExc;
    logic                   intPending;
    excPkg::addrFault       fault;

    memReg uMemReg (
        .clk            (clk),
        .arstN          (arstN),
        .memFlush       (memFlush),
        .memWr          (memWr),
        .exeAluOut      (exeAluOut),
        .exeStoreData   (exeStoreData),
        .exePc          (exePc),
        .exeLoadType    (exeLoadType),
        .exeStoreType   (exeStoreType),
        .exeExc         (exeExc),
        .exeIsEret      (exeIsEret),
        .exeInDelaySlot (exeInDelaySlot),
        .memAluOut      (memAluOut),
        .memStoreData   (memStoreData),
        .memPc          (memPc),  // also leaves the stage
        .memLoadType    (memLoadType),
        .memStoreType   (memStoreType),
        .memExc         (memExc),
        .memIsEret      (memIsEret),
        .memInDelaySlot (memInDelaySlot)
    );

    exceptionUnit uExceptionUnit (
        .memExc     (memExc),
        .interrupt  (interrupt),
        .statusIm   (statusIm),
        .statusIe   (statusIe),
        .pipeExc    (pipeExc),
        .intPending (intPending)
    );

    storeAligner uStoreAligner (
        .memAluOut    (memAluOut),
        .memStoreData (memStoreData),
        .memLoadType  (memLoadType),
        .memStoreType (memStoreType),
        .wstrb        (wstrb),
        .wdata        (wdata),
        .fault        (fault)
    );

    memCommit uMemCommit (
        .clk            (clk),
        .arstN          (arstN),
        .memWr          (memWr),
        .memFlush       (memFlush),
        .dreqValid      (dreqValid),
        .pipeExc        (pipeExc),
        .intPending     (intPending),
        .fault          (fault),
        .memPc          (memPc),
        .memAluOut      (memAluOut),
        .memInDelaySlot (memInDelaySlot),
        .memIsEret      (memIsEret),
        .memLoadType    (memLoadType),
        .memStoreType   (memStoreType),
        .flushException (flushException),
        .excCodeOut     (excCodeOut),
        .excVector      (excVector),
        .cp0Epc         (cp0Epc),
        .cp0Bd          (cp0Bd),
        .cp0BadVaddr    (cp0BadVaddr),
        .cp0Exl         (cp0Exl),
        .dbusValid      (dbusValid),
        .dbusWrite      (dbusWrite),
        .dbusAddr       (dbusAddr)
    );

endmodule

//--- sim/tbMemStage.sv
// testbench for the memory stage, checks bus lanes, exceptions and CP0 state by assertions
`include "memStage_params.svh"

module tbMemStage;

    localparam int testCycles = 80;  // upper bound on clock cycles of all tests

    logic                   clk;
    logic                   arstN;
    logic                   memFlush;
    logic                   memWr;
    logic                   dreqValid;
    logic [`XLEN-1:0]       exeAluOut;
    logic [`XLEN-1:0]       exeStoreData;
    logic [`XLEN-1:0]       exePc;
    pipeTypesPkg::loadType  exeLoadType;
    pipeTypesPkg::storeType exeStoreType;
    excPkg::excFlags        exeExc;
    logic                   exeIsEret;
    logic                   exeInDelaySlot;
    logic [`INT_NUM-1:0]    interrupt;
    logic [`INT_NUM+1:2]    statusIm;
    logic                   statusIe;
    logic [`XLEN-1:0]       memPc;
    logic                   flushException;
    excPkg::excCode         excCodeOut;
    logic [`XLEN-1:0]       excVector;
    logic [`XLEN-1:0]       cp0Epc;
    logic                   cp0Bd;
    logic [`XLEN-1:0]       cp0BadVaddr;
    logic                   cp0Exl;
    logic                   dbusValid;
    logic                   dbusWrite;
    logic [`XLEN-1:0]       dbusAddr;
    logic [3:0]             wstrb;
    logic [`XLEN-1:0]       wdata;

    // reference CP0 state
    logic [31:0] modelEpc;
    logic [31:0] modelBadVaddr;
    logic        modelBd;
    logic        modelExl;

    // expectations for the instruction held in the memory stage
    logic        checkOn;
    logic        archOn;
    logic        expStore;
    logic        expFlush;
    logic        expDbusValid;
    logic        expDbusWrite;
    logic [4:0]  expCode;
    logic [3:0]  expWstrb;
    logic [31:0] expVector;
    logic [31:0] expAddr;
    logic [31:0] expPc;
    logic [31:0] expWdata;
    logic [31:0] expEpc;
    logic [31:0] expBadVaddr;
    logic        expBd;
    logic        expExl;

    logic [31:0] lfsrState;
    string       testName;
    int          errCount;
    int          testErrs;
    int          testsRun;
    int          testsFailed;

    memStage DUT (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic badAlign(input logic [1:0] size, input logic [1:0] low);
        return (size == 2'd1 && low[0]) || (size == 2'd2 && low != 2'b00);
    endfunction

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("ERR %s %s exp %h act %h", testName, what, exp, act);
        errCount++;
        testErrs++;
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrs = 0;
    endtask

    task automatic endTest();
        testsRun++;
        if (testErrs == 0) begin
            $display("test %s passed", testName);
        end else begin
            testsFailed++;
            $display("test %s failed with %0d errors", testName, testErrs);
        end
    endtask

    task automatic clearExe();
        exeAluOut      = '0;
        exeStoreData   = '0;
        exePc          = '0;
        exeLoadType    = '0;
        exeStoreType   = '0;
        exeExc         = '0;
        exeIsEret      = 1'b0;
        exeInDelaySlot = 1'b0;
    endtask

    // expected outputs from the priority rules, then the next CP0 state
    task automatic predict(input logic [31:0] addr, input logic [31:0] data,
                           input logic [31:0] pc, input pipeTypesPkg::loadType ld,
                           input pipeTypesPkg::storeType st, input excPkg::excFlags ex,
                           input logic eret, input logic ds);
        logic       pend;
        logic [4:0] code;
        pend = 1'b0;
        for (int i = 0; i < `INT_NUM; i++) begin
            pend = pend | (interrupt[i] & statusIm[i+2]);  // line i on IM bit i+2
        end
        pend = pend & statusIe;
        code = (pend && !modelExl) ? 5'd0 :
               ex.fetchAdEL        ? 5'd4 :
               ex.reservedInstr    ? 5'd10 :
               ex.syscall          ? 5'd8 :
               ex.breakPt          ? 5'd9 :
               ex.overflow         ? 5'd12 :
               (ld.readMem && badAlign(ld.size, addr[1:0])) ? 5'd4 :
               (st.dmWr && badAlign(st.size, addr[1:0]))    ? 5'd5 : 5'd31;
        expCode      = code;
        expFlush     = (code != 5'd31) || eret;
        expVector    = (code == 5'd31) ? modelEpc : `EXC_VEC_BASE + 32'h180;
        expDbusValid = dreqValid && (ld.readMem || st.dmWr) && !expFlush;
        expDbusWrite = st.dmWr;
        expAddr      = addr;
        expPc        = pc;
        expStore     = st.dmWr && code == 5'd31;
        expWstrb     = (st.size == 2'd0) ? 4'b0001 << addr[1:0] :
                       (st.size == 2'd1) ? (addr[1] ? 4'b1100 : 4'b0011) : 4'b1111;
        expWdata     = (st.size == 2'd0) ? {4{data[7:0]}} :
                       (st.size == 2'd1) ? {2{data[15:0]}} : data;
        if (code != 5'd31) begin
            modelEpc = ds ? pc - 32'd4 : pc;
            modelBd  = ds;
            modelExl = 1'b1;
            if (code == 5'd4 && ex.fetchAdEL) begin
                modelBadVaddr = pc;
            end else if (code == 5'd4 || code == 5'd5) begin
                modelBadVaddr = addr;
            end
        end else if (eret) begin
            modelExl = 1'b0;
        end
    endtask

    // one instruction through the stage, called 10 units after a rising edge
    task automatic runInstr(input logic [`INT_NUM-1:0] irq, input logic flushIt);
        logic [31:0]            addr;
        logic [31:0]            data;
        logic [31:0]            pc;
        pipeTypesPkg::loadType  ld;
        pipeTypesPkg::storeType st;
        excPkg::excFlags        ex;
        logic                   eret;
        logic                   ds;
        addr = flushIt ? '0 : exeAluOut;  // a flushed capture leaves a bubble
        data = flushIt ? '0 : exeStoreData;
        pc   = flushIt ? '0 : exePc;
        ld   = flushIt ? '0 : exeLoadType;
        st   = flushIt ? '0 : exeStoreType;
        ex   = flushIt ? '0 : exeExc;
        eret = flushIt ? 1'b0 : exeIsEret;
        ds   = flushIt ? 1'b0 : exeInDelaySlot;
        memWr = 1'b1;
        memFlush = flushIt;
        @(posedge clk);
        #10;
        memFlush = 1'b0;
        interrupt = irq;
        predict(addr, data, pc, ld, st, ex, eret, ds);
        checkOn = 1'b1;
        clearExe();
        @(posedge clk);
        #10;
        checkOn = 1'b0;
        interrupt = '0;
        expEpc = modelEpc;
        expBd = modelBd;
        expBadVaddr = modelBadVaddr;
        expExl = modelExl;
        archOn = 1'b1;
        @(posedge clk);
        #10;
        archOn = 1'b0;
    endtask

    codeOk: assert property (@(posedge clk) disable iff (!arstN)
        checkOn |-> excCodeOut == expCode)
        else mismatch("excCodeOut", $sampled(expCode), $sampled(excCodeOut));
    flushOk: assert property (@(posedge clk) disable iff (!arstN)
        checkOn |-> flushException == expFlush)
        else mismatch("flushException", $sampled(expFlush), $sampled(flushException));
    vectorOk: assert property (@(posedge clk) disable iff (!arstN)
        checkOn && expFlush |-> excVector == expVector)
        else mismatch("excVector", $sampled(expVector), $sampled(excVector));
    validOk: assert property (@(posedge clk) disable iff (!arstN)
        checkOn |-> dbusValid == expDbusValid)
        else mismatch("dbusValid", $sampled(expDbusValid), $sampled(dbusValid));
    writeOk: assert property (@(posedge clk) disable iff (!arstN)
        checkOn |-> dbusWrite == expDbusWrite)
        else mismatch("dbusWrite", $sampled(expDbusWrite), $sampled(dbusWrite));
    addrOk: assert property (@(posedge clk) disable iff (!arstN)
        checkOn |-> dbusAddr == expAddr)
        else mismatch("dbusAddr", $sampled(expAddr), $sampled(dbusAddr));
    pcOk: assert property (@(posedge clk) disable iff (!arstN)
        checkOn |-> memPc == expPc)
        else mismatch("memPc", $sampled(expPc), $sampled(memPc));
    wstrbOk: assert property (@(posedge clk) disable iff (!arstN)
        checkOn && expStore |-> wstrb == expWstrb)
        else mismatch("wstrb", $sampled(expWstrb), $sampled(wstrb));
    wdataOk: assert property (@(posedge clk) disable iff (!arstN)
        checkOn && expStore |-> wdata == expWdata)
        else mismatch("wdata", $sampled(expWdata), $sampled(wdata));
    epcOk: assert property (@(posedge clk) disable iff (!arstN)
        archOn |-> cp0Epc == expEpc)
        else mismatch("cp0Epc", $sampled(expEpc), $sampled(cp0Epc));
    bdOk: assert property (@(posedge clk) disable iff (!arstN)
        archOn |-> cp0Bd == expBd)
        else mismatch("cp0Bd", $sampled(expBd), $sampled(cp0Bd));
    badVaddrOk: assert property (@(posedge clk) disable iff (!arstN)
        archOn |-> cp0BadVaddr == expBadVaddr)
        else mismatch("cp0BadVaddr", $sampled(expBadVaddr), $sampled(cp0BadVaddr));
    exlOk: assert property (@(posedge clk) disable iff (!arstN)
        archOn |-> cp0Exl == expExl)
        else mismatch("cp0Exl", $sampled(expExl), $sampled(cp0Exl));

    initial begin
        #((testCycles + 20) * 100);
        $display("watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        arstN = 1'b0;
        memWr = 1'b0;
        memFlush = 1'b0;
        dreqValid = 1'b1;
        interrupt = '0;
        statusIm = '0;
        statusIe = 1'b0;
        clearExe();
        {checkOn, archOn, modelBd, modelExl} = '0;
        modelEpc = '0;
        modelBadVaddr = '0;
        lfsrState = 32'd64;
        errCount = 0;
        testsRun = 0;
        testsFailed = 0;
        repeat (2) @(posedge clk);
        #10;
        arstN = 1'b1;

        startTest("alignedAccess");
        for (int size = 0; size < 3; size++) begin
            repeat (3) begin
                exeAluOut = takeBits(32) & ~((32'd1 << size) - 32'd1);
                exeStoreData = takeBits(32);
                exePc = takeBits(30) << 2;
                exeStoreType = {1'b1, size[1:0]};
                runInstr('0, 1'b0);
            end
        end
        for (int j = 0; j < 2; j++) begin
            dreqValid = (j != 0);  // first load without a cache request
            exeAluOut = takeBits(32) & 32'hFFFF_FFFC;
            exePc = takeBits(30) << 2;
            exeLoadType = {1'b1, 2'd2};  // lw
            runInstr('0, 1'b0);
        end
        endTest();

        startTest("misaligned");
        for (int k = 0; k < 4; k++) begin
            exeAluOut = (takeBits(32) & 32'hFFFF_FFFC) | (k[0] ? 32'd2 : 32'd1);
            exePc = takeBits(30) << 2;
            if (k < 2) begin
                exeLoadType = {1'b1, k[0] ? 2'd2 : 2'd1};
            end else begin
                exeStoreType = {1'b1, k[0] ? 2'd2 : 2'd1};
                exeStoreData = takeBits(32);
            end
            runInstr('0, 1'b0);
        end
        endTest();

        startTest("eret");
        exePc = takeBits(30) << 2;
        exeIsEret = 1'b1;
        runInstr('0, 1'b0);
        endTest();

        startTest("interrupt");
        statusIe = 1'b1;
        statusIm = 6'b111110;  // IM2 off
        exePc = takeBits(30) << 2;
        runInstr(6'b000001, 1'b0);
        statusIe = 1'b0;
        statusIm = 6'b111111;
        exePc = takeBits(30) << 2;
        runInstr(6'b000100, 1'b0);
        statusIe = 1'b1;
        exePc = takeBits(30) << 2;
        runInstr(6'b000100, 1'b0);
        exePc = takeBits(30) << 2;
        runInstr(6'b010000, 1'b0);  // EXL now set
        endTest();

        startTest("syscallDelaySlot");
        statusIe = 1'b0;
        exePc = takeBits(30) << 2;
        exeExc.syscall = 1'b1;
        exeExc.overflow = 1'b1;
        exeInDelaySlot = 1'b1;
        runInstr('0, 1'b0);
        endTest();

        startTest("stallFlush");
        exeAluOut = takeBits(32) & 32'hFFFF_FFFC;
        exeStoreData = takeBits(32);
        exePc = takeBits(30) << 2;
        exeStoreType = {1'b1, 2'd2};
        memWr = 1'b1;
        @(posedge clk);
        #10;
        predict(exeAluOut, exeStoreData, exePc, exeLoadType, exeStoreType, exeExc,
                exeIsEret, exeInDelaySlot);
        checkOn = 1'b1;
        memWr = 1'b0;
        exeAluOut = takeBits(32);  // next instruction waits in execute
        exeStoreData = takeBits(32);
        repeat (2) begin
            @(posedge clk);
            #10;
        end
        checkOn = 1'b0;
        clearExe();
        memWr = 1'b1;
        @(posedge clk);
        #10;
        exeAluOut = takeBits(32) & 32'hFFFF_FFFC;
        exePc = takeBits(30) << 2;
        exeLoadType = {1'b1, 2'd2};
        runInstr('0, 1'b1);
        endTest();

        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+rtl
rtl/pipeTypesPkg.sv
rtl/excPkg.sv
rtl/memReg.sv
rtl/exceptionUnit.sv
rtl/storeAligner.sv
rtl/memCommit.sv
rtl/memStage.sv
sim/tbMemStage.sv

//--- Bender.yml
package:
  name: memStage

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pipeTypesPkg.sv
      - rtl/excPkg.sv
      - rtl/memReg.sv
      - rtl/exceptionUnit.sv
      - rtl/storeAligner.sv
      - rtl/memCommit.sv
      - rtl/memStage.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tbMemStage.sv
